/* mem_ctrl.sv */
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                       clkConstrained,
    input  logic                       rst,
    input  logic                       inst_start,
    output logic                       inst_ready,
    input  logic [31:0]                i_addr,
    output logic [31:0]                inst,
    output logic                       inst_valid,
    input  logic                       d_cmd_start,
    input  logic                       d_cmd_write,
    output logic                       d_cmd_ready,
    input  logic [31:0]                d_addr,
    input  logic [31:0]                wdata,
    input  logic [31:0]                wmask,
    output logic [31:0]                rdata,
    output logic                       rdata_valid,
    input  logic                       exited,
    output logic [soc_pkg::RAM_AW-1:0] ram_addr,
    output logic                       ram_we,
    output logic [31:0]                ram_wdata,
    output logic [31:0]                ram_wmask,
    input  logic [31:0]                ram_rdata,
    output logic                       reg_sel,
    output logic [4:0]                 reg_offset,
    output logic                       reg_we,
    output logic [31:0]                reg_wdata,
    output logic [31:0]                reg_wmask,
    input  logic [31:0]                reg_rdata
);

    localparam int AW = soc_pkg::RAM_AW;

    // issue slot, one access per cycle
    logic          iss_valid;
    logic          iss_inst;
    logic          iss_write;
    logic          iss_reg;
    logic [AW-1:0] iss_word;
    logic [4:0]    iss_offset;
    logic [31:0]   iss_wdata;
    logic [31:0]   iss_wmask;
    // fetch held back by a colliding data command
    logic          hold_valid;
    logic [AW-1:0] hold_word;
    // read data arriving from RAM or registers
    logic          ret_valid;
    logic          ret_inst;
    logic          ret_reg;
    logic          d_is_reg;

    assign d_is_reg = (d_addr[31:28] == soc_pkg::MMIO_BASE[31:28]);

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            iss_valid <= 1'b0;
            iss_inst <= 1'b0;
            iss_write <= 1'b0;
            iss_reg <= 1'b0;
            hold_valid <= 1'b0;
            ret_valid <= 1'b0;
            ret_inst <= 1'b0;
            ret_reg <= 1'b0;
            inst_valid <= 1'b0;
            rdata_valid <= 1'b0;
            inst_ready <= 1'b1;
            d_cmd_ready <= 1'b1;
        end else begin
            // data wins a same-edge collision
            if (d_cmd_start) begin
                iss_valid <= 1'b1;
                iss_inst <= 1'b0;
                iss_write <= d_cmd_write;
                iss_reg <= d_is_reg;
            end else if (inst_start || hold_valid) begin
                iss_valid <= 1'b1;
                iss_inst <= 1'b1;
                iss_write <= 1'b0;
                iss_reg <= 1'b0;
            end else begin
                iss_valid <= 1'b0;
            end
            hold_valid <= d_cmd_start && (inst_start || hold_valid);

            ret_valid <= iss_valid && !iss_write;
            ret_inst <= iss_inst;
            ret_reg <= iss_reg;

            inst_valid <= ret_valid && ret_inst;
            rdata_valid <= ret_valid && !ret_inst;

            // ready comes back with the valid, or right after a write
            if (ret_valid && ret_inst) begin
                inst_ready <= 1'b1;
            end
            if ((ret_valid && !ret_inst) || (iss_valid && iss_write)) begin
                d_cmd_ready <= 1'b1;
            end
            if (inst_start) begin
                inst_ready <= 1'b0;
            end
            if (d_cmd_start) begin
                d_cmd_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (d_cmd_start) begin
            iss_word <= d_addr[AW+1:2];
            iss_offset <= d_addr[4:0];
            iss_wdata <= wdata;
            iss_wmask <= wmask;
        end else if (inst_start) begin
            iss_word <= i_addr[AW+1:2];
        end else if (hold_valid) begin
            iss_word <= hold_word;
        end
        if (inst_start) begin
            hold_word <= i_addr[AW+1:2];
        end
        if (ret_valid && ret_inst) begin
            inst <= ram_rdata;
        end
        if (ret_valid && !ret_inst) begin
            rdata <= ret_reg ? reg_rdata : ram_rdata;
        end
    end

    // writes are dropped once the exit flag is up
    assign ram_addr = iss_word;
    assign ram_we = iss_valid && iss_write && !iss_reg && !exited;
    assign ram_wdata = iss_wdata;
    assign ram_wmask = iss_wmask;

    assign reg_sel = iss_valid && iss_reg;
    assign reg_offset = iss_offset;
    assign reg_we = reg_sel && iss_write && !exited;
    assign reg_wdata = iss_wdata;
    assign reg_wmask = iss_wmask;

    a_inst_start_ready: assert property (
        @(posedge clkConstrained) disable iff (rst)
        inst_start |-> inst_ready
    ) else $error("inst_start while inst_ready low");

    a_d_start_ready: assert property (
        @(posedge clkConstrained) disable iff (rst)
        d_cmd_start |-> d_cmd_ready
    ) else $error("d_cmd_start while d_cmd_ready low");

    a_valid_onehot: assert property (
        @(posedge clkConstrained) disable iff (rst)
        !(inst_valid && rdata_valid)
    ) else $error("inst_valid and rdata_valid in the same cycle");

endmodule

/* mmio_regs.sv */
`timescale 1ns/1ps

module mmio_regs (
    input  logic        clkConstrained,
    input  logic        rst,
    input  logic        reg_sel,
    input  logic [4:0]  reg_offset,
    input  logic        reg_we,
    input  logic [31:0] reg_wdata,
    input  logic [31:0] reg_wmask,
    input  logic [63:0] cycle,
    input  logic [63:0] mtime,
    output logic [31:0] reg_rdata,
    output logic [31:0] gp,
    output logic [5:0]  led,
    output logic        exited,
    output logic        timer_irq
);

    logic [63:0] mtimecmp;
    logic [31:0] rd_mux;

    function automatic logic [31:0] merge(input logic [31:0] old_val);
        merge = (old_val & ~reg_wmask) | (reg_wdata & reg_wmask);
    endfunction

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            mtimecmp <= '1;
            gp <= 32'd0;
            exited <= 1'b0;
        end else if (reg_we) begin
            case (reg_offset)
                soc_pkg::REG_MTIMECMP_LO: mtimecmp[31:0] <= merge(mtimecmp[31:0]);
                soc_pkg::REG_MTIMECMP_HI: mtimecmp[63:32] <= merge(mtimecmp[63:32]);
                soc_pkg::REG_GP: gp <= merge(gp);
                soc_pkg::REG_EXIT: exited <= 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_offset)
            soc_pkg::REG_MTIME_LO: rd_mux = mtime[31:0];
            soc_pkg::REG_MTIME_HI: rd_mux = mtime[63:32];
            soc_pkg::REG_MTIMECMP_LO: rd_mux = mtimecmp[31:0];
            soc_pkg::REG_MTIMECMP_HI: rd_mux = mtimecmp[63:32];
            soc_pkg::REG_CYCLE_LO: rd_mux = cycle[31:0];
            soc_pkg::REG_CYCLE_HI: rd_mux = cycle[63:32];
            soc_pkg::REG_GP: rd_mux = gp;
            soc_pkg::REG_EXIT: rd_mux = {31'd0, exited};
            default: rd_mux = 32'd0;
        endcase
    end

    // read data lands one cycle after the select
    always_ff @(posedge clkConstrained) begin
        if (reg_sel) begin
            reg_rdata <= rd_mux;
        end
    end

    // leds are active low
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            led <= 6'h3F;
        end else begin
            led <= ~gp[5:0];
        end
    end

    assign timer_irq = (mtime >= mtimecmp);

    // exit flag is sticky until the next reset
    a_exit_sticky: assert property (
        @(posedge clkConstrained) disable iff (rst)
        exited |=> exited
    ) else $error("exited fell without reset");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_soc_top \
    -f vlog.f -o tb_soc_top \
    && ./obj_dir/tb_soc_top > sim.log 2>&1 \
    && ! grep -q "Done: errors found" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* soc_pkg.sv */
package soc_pkg;

    // core clock in MHz, also cycles per microsecond
    localparam int FMAX_MHZ = 18;

    // prescaler for the microsecond counter
    localparam int PRESC_W = $clog2(FMAX_MHZ);
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(FMAX_MHZ - 1);

    // shared instruction/data RAM
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // register window, top nibble all ones
    localparam logic [31:0] MMIO_BASE = 32'hF000_0000;

    // register offsets, low 5 bits of the byte address
    localparam logic [4:0] REG_MTIME_LO = 5'h00;
    localparam logic [4:0] REG_MTIME_HI = 5'h04;
    localparam logic [4:0] REG_MTIMECMP_LO = 5'h08;
    localparam logic [4:0] REG_MTIMECMP_HI = 5'h0C;
    localparam logic [4:0] REG_CYCLE_LO = 5'h10;
    localparam logic [4:0] REG_CYCLE_HI = 5'h14;
    localparam logic [4:0] REG_GP = 5'h18;
    // any write sets the sticky flag
    localparam logic [4:0] REG_EXIT = 5'h1C;

endpackage

/* soc_testdata.txt */
# kind d_addr i_addr wdata wmask d_exp i_exp mode (hex except mode)
# W write, R read, I fetch, P paired, G gp/led, X exited, T timer; mode 1 cycle, 2 mtime
G 00000000 00000000 00000000 00000000 00000000 00000000 0
W 00000000 00000000 12345678 ffffffff 00000000 00000000 0
W 00000004 00000000 a5a5a5a5 ffffffff 00000000 00000000 0
W 00000040 00000000 deadbeef ffffffff 00000000 00000000 0
W 00000ffc 00000000 0badf00d ffffffff 00000000 00000000 0
R 00000000 00000000 00000000 00000000 12345678 00000000 0
I 00000000 00000004 00000000 00000000 00000000 a5a5a5a5 0
W 00000000 00000000 ffff0000 0000ffff 00000000 00000000 0
W 00000004 00000000 5a5a5a5a ff00ff00 00000000 00000000 0
W 00000040 00000000 00000000 0000000f 00000000 00000000 0
W 00000ffc 00000000 f0000000 f0000000 00000000 00000000 0
R 00000000 00000000 00000000 00000000 12340000 00000000 0
I 00000000 00000004 00000000 00000000 00000000 5aa55aa5 0
R 00000040 00000000 00000000 00000000 deadbee0 00000000 0
I 00000000 00000ffc 00000000 00000000 00000000 fbadf00d 0
R 00001000 00000000 00000000 00000000 12340000 00000000 0
P 00000040 00000000 00000000 00000000 deadbee0 12340000 0
P 00000ffc 00000004 00000000 00000000 fbadf00d 5aa55aa5 0
P 00000004 00000004 00000000 00000000 5aa55aa5 5aa55aa5 0
R f0000010 00000000 00000000 00000000 00000000 00000000 1
R f0000014 00000000 00000000 00000000 00000000 00000000 0
R f0000000 00000000 00000000 00000000 00000000 00000000 2
R f0000008 00000000 00000000 00000000 ffffffff 00000000 0
W f0000008 00000000 00000008 ffffffff 00000000 00000000 0
W f000000c 00000000 00000000 ffffffff 00000000 00000000 0
R f000000c 00000000 00000000 00000000 00000000 00000000 0
T 00000000 00000000 00000000 00000000 00000008 00000000 0
W f0000018 00000000 0000002a ffffffff 00000000 00000000 0
G 00000000 00000000 00000000 00000000 0000002a 00000000 0
W f0000018 00000000 12345635 0000000f 00000000 00000000 0
G 00000000 00000000 00000000 00000000 00000025 00000000 0
R f0000018 00000000 00000000 00000000 00000025 00000000 0
R f0000002 00000000 00000000 00000000 00000000 00000000 0
X 00000000 00000000 00000000 00000000 00000000 00000000 0
W f000001c 00000000 00000000 00000000 00000000 00000000 0
X 00000000 00000000 00000000 00000000 00000001 00000000 0
R f000001c 00000000 00000000 00000000 00000001 00000000 0
W 00000000 00000000 ffffffff ffffffff 00000000 00000000 0
W f0000018 00000000 ffffffff ffffffff 00000000 00000000 0
R 00000000 00000000 00000000 00000000 12340000 00000000 0
I 00000000 00000000 00000000 00000000 00000000 12340000 0
G 00000000 00000000 00000000 00000000 00000025 00000000 0

/* soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic        clkConstrained,
    input  logic        rst,
    input  logic        inst_start,
    output logic        inst_ready,
    input  logic [31:0] i_addr,
    output logic [31:0] inst,
    output logic        inst_valid,
    input  logic        d_cmd_start,
    input  logic        d_cmd_write,
    output logic        d_cmd_ready,
    input  logic [31:0] d_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] wmask,
    output logic [31:0] rdata,
    output logic        rdata_valid,
    output logic [5:0]  led,
    output logic [31:0] gp,
    output logic        exited,
    output logic        timer_irq
);

    logic [soc_pkg::RAM_AW-1:0] ram_addr;
    logic                       ram_we;
    logic [31:0]                ram_wdata;
    logic [31:0]                ram_wmask;
    logic [31:0]                ram_rdata;
    logic                       reg_sel;
    logic [4:0]                 reg_offset;
    logic                       reg_we;
    logic [31:0]                reg_wdata;
    logic [31:0]                reg_wmask;
    logic [31:0]                reg_rdata;
    logic [63:0]                cycle;
    logic [63:0]                mtime;

    mem_ctrl u_mem_ctrl (
        .clkConstrained(clkConstrained),
        .rst(rst),
        .inst_start(inst_start),
        .inst_ready(inst_ready),
        .i_addr(i_addr),
        .inst(inst),
        .inst_valid(inst_valid),
        .d_cmd_start(d_cmd_start),
        .d_cmd_write(d_cmd_write),
        .d_cmd_ready(d_cmd_ready),
        .d_addr(d_addr),
        .wdata(wdata),
        .wmask(wmask),
        .rdata(rdata),
        .rdata_valid(rdata_valid),
        .exited(exited),
        .ram_addr(ram_addr),
        .ram_we(ram_we),
        .ram_wdata(ram_wdata),
        .ram_wmask(ram_wmask),
        .ram_rdata(ram_rdata),
        .reg_sel(reg_sel),
        .reg_offset(reg_offset),
        .reg_we(reg_we),
        .reg_wdata(reg_wdata),
        .reg_wmask(reg_wmask),
        .reg_rdata(reg_rdata)
    );

    word_ram u_word_ram (
        .clkConstrained(clkConstrained),
        .ram_addr(ram_addr),
        .ram_we(ram_we),
        .ram_wdata(ram_wdata),
        .ram_wmask(ram_wmask),
        .ram_rdata(ram_rdata)
    );

    mmio_regs u_mmio_regs (
        .clkConstrained(clkConstrained),
        .rst(rst),
        .reg_sel(reg_sel),
        .reg_offset(reg_offset),
        .reg_we(reg_we),
        .reg_wdata(reg_wdata),
        .reg_wmask(reg_wmask),
        .cycle(cycle),
        .mtime(mtime),
        .reg_rdata(reg_rdata),
        .gp(gp),
        .led(led),
        .exited(exited),
        .timer_irq(timer_irq)
    );

    time_counters u_time_counters (
        .clkConstrained(clkConstrained),
        .rst(rst),
        .cycle(cycle),
        .mtime(mtime)
    );

endmodule

/* tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;

    localparam int HALF_PERIOD = 20;
    localparam int VALID_WAIT = 8;

    logic        clkConstrained = 1'b0;
    logic        rst;
    logic        inst_start;
    logic        inst_ready;
    logic [31:0] i_addr;
    logic [31:0] inst;
    logic        inst_valid;
    logic        d_cmd_start;
    logic        d_cmd_write;
    logic        d_cmd_ready;
    logic [31:0] d_addr;
    logic [31:0] wdata;
    logic [31:0] wmask;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic [5:0]  led;
    logic [31:0] gp;
    logic        exited;
    logic        timer_irq;

    int edge_cnt = 0;
    int errors = 0;
    int checks = 0;
    bit loaded = 1'b0;

    // one entry per test data line
    logic [7:0]  k_q[$];
    logic [31:0] da_q[$];
    logic [31:0] ia_q[$];
    logic [31:0] wd_q[$];
    logic [31:0] wm_q[$];
    logic [31:0] de_q[$];
    logic [31:0] ie_q[$];
    int          md_q[$];

    soc_top DUT (.*);

    always #HALF_PERIOD clkConstrained = ~clkConstrained;

    // edge 1 is the first edge with rst low
    always @(posedge clkConstrained) begin
        if (rst) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Fail %0t: %s is 0x%h, expected 0x%h", $time, what, got, want);
        end
    endtask

    task automatic check_seen(input string what, input bit seen);
        checks++;
        assert (seen) else begin
            errors++;
            $display("%0t: no %s within %0d cycles", $time, what, VALID_WAIT);
        end
    endtask

    task automatic wait_ready(input bit fetch);
        int n = 0;
        while (!(fetch ? inst_ready : d_cmd_ready) && n < VALID_WAIT) begin
            @(posedge clkConstrained);
            #2;
            n++;
        end
        check_seen(fetch ? "inst_ready" : "d_cmd_ready", fetch ? inst_ready : d_cmd_ready);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] mask);
        wait_ready(1'b0);
        d_cmd_start = 1'b1;
        d_cmd_write = 1'b1;
        d_addr = addr;
        wdata = data;
        wmask = mask;
        @(posedge clkConstrained);
        #2;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        check_value($sformatf("d_cmd_ready after write to 0x%h", addr),
                    {31'd0, d_cmd_ready}, 32'd0);
        @(posedge clkConstrained);
        #2;
        check_value($sformatf("d_cmd_ready a cycle later, write to 0x%h", addr),
                    {31'd0, d_cmd_ready}, 32'd1);
    endtask

    // data read, fetch, or both started on the same edge
    task automatic issue_reads(input bit use_d, input bit use_i, input logic [31:0] da,
                               input logic [31:0] ia, input logic [31:0] d_exp,
                               input logic [31:0] i_exp, input int mode);
        int acc;
        int n;
        int d_lat;
        int i_lat;
        logic [31:0] d_got;
        logic [31:0] i_got;
        logic [31:0] want;
        if (use_d) begin
            wait_ready(1'b0);
        end
        if (use_i) begin
            wait_ready(1'b1);
        end
        d_cmd_start = use_d;
        d_cmd_write = 1'b0;
        d_addr = da;
        inst_start = use_i;
        i_addr = ia;
        acc = edge_cnt + 1;
        @(posedge clkConstrained);
        #2;
        d_cmd_start = 1'b0;
        inst_start = 1'b0;
        d_lat = -1;
        i_lat = -1;
        n = 0;
        while (n < VALID_WAIT && ((use_d && d_lat < 0) || (use_i && i_lat < 0))) begin
            @(posedge clkConstrained);
            #2;
            n++;
            if (rdata_valid) begin
                d_lat = n;
                d_got = rdata;
            end
            if (inst_valid) begin
                i_lat = n;
                i_got = inst;
            end
        end
        // counters as they stood at the acceptance edge
        case (mode)
            1: want = 32'(acc);
            2: want = 32'(acc / soc_pkg::FMAX_MHZ);
            default: want = d_exp;
        endcase
        if (use_d) begin
            check_seen($sformatf("rdata_valid for read of 0x%h", da), d_lat >= 0);
            if (d_lat >= 0) begin
                check_value($sformatf("rdata latency for 0x%h", da), d_lat, 2);
                check_value($sformatf("rdata for 0x%h", da), d_got, want);
            end
        end
        if (use_i) begin
            check_seen($sformatf("inst_valid for fetch of 0x%h", ia), i_lat >= 0);
            if (i_lat >= 0) begin
                check_value($sformatf("inst latency for 0x%h", ia), i_lat, use_d ? 3 : 2);
                check_value($sformatf("inst for 0x%h", ia), i_got, i_exp);
            end
        end
    endtask

    task automatic check_gp_led(input logic [31:0] exp);
        // led trails gp by one register
        @(posedge clkConstrained);
        #2;
        check_value("gp", gp, exp);
        check_value("led", {26'd0, led}, {26'd0, ~exp[5:0]});
    endtask

    task automatic wait_timer_irq(input logic [31:0] cmp);
        bit want;
        do begin
            want = (edge_cnt / soc_pkg::FMAX_MHZ) >= int'(cmp);
            check_value($sformatf("timer_irq at edge %0d", edge_cnt),
                        {31'd0, timer_irq}, {31'd0, want});
            if (!want) begin
                @(posedge clkConstrained);
                #2;
            end
        end while (!want);
    endtask

    initial begin
        int fd;
        int code;
        string line;
        logic [7:0] kind;
        logic [31:0] da;
        logic [31:0] ia;
        logic [31:0] wd;
        logic [31:0] wm;
        logic [31:0] de;
        logic [31:0] ie;
        int mode;
        rst = 1'b1;
        inst_start = 1'b0;
        i_addr = 32'd0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr = 32'd0;
        wdata = 32'd0;
        wmask = 32'd0;
        fd = $fopen("soc_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open soc_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // skip comments and blank lines
                if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%s %h %h %h %h %h %h %d",
                                   kind, da, ia, wd, wm, de, ie, mode);
                    if (code == 8) begin
                        k_q.push_back(kind);
                        da_q.push_back(da);
                        ia_q.push_back(ia);
                        wd_q.push_back(wd);
                        wm_q.push_back(wm);
                        de_q.push_back(de);
                        ie_q.push_back(ie);
                        md_q.push_back(mode);
                    end else begin
                        errors++;
                        $display("malformed test data line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (8) @(posedge clkConstrained);
        #2;
        rst = 1'b0;
        check_value("ready levels after reset", {30'd0, inst_ready, d_cmd_ready}, 32'd3);
        check_value("valids after reset", {30'd0, inst_valid, rdata_valid}, 32'd0);
        check_value("exited and timer_irq after reset", {30'd0, exited, timer_irq}, 32'd0);
        check_value("gp after reset", gp, 32'd0);
        check_value("led after reset", {26'd0, led}, 32'h3F);
        for (int i = 0; i < k_q.size(); i++) begin
            case (k_q[i])
                "W": write_word(da_q[i], wd_q[i], wm_q[i]);
                "R": issue_reads(1'b1, 1'b0, da_q[i], ia_q[i], de_q[i], ie_q[i], md_q[i]);
                "I": issue_reads(1'b0, 1'b1, da_q[i], ia_q[i], de_q[i], ie_q[i], md_q[i]);
                "P": issue_reads(1'b1, 1'b1, da_q[i], ia_q[i], de_q[i], ie_q[i], md_q[i]);
                "G": check_gp_led(de_q[i]);
                "X": check_value("exited", {31'd0, exited}, de_q[i]);
                "T": wait_timer_irq(de_q[i]);
                default: begin
                    errors++;
                    $display("unknown kind %s on test data entry %0d", k_q[i], i);
                end
            endcase
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // run length follows the number of data lines
    initial begin
        int limit;
        wait (loaded);
        limit = 20 * k_q.size() + 100;
        repeat (limit) @(posedge clkConstrained);
        $display("watchdog expired after %0d cycles with %0d checks and %0d errors",
                 limit, checks, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* time_counters.sv */
`timescale 1ns/1ps

module time_counters (
    input  logic        clkConstrained,
    input  logic        rst,
    output logic [63:0] cycle,
    output logic [63:0] mtime
);

    logic [soc_pkg::PRESC_W-1:0] presc;

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            cycle <= 64'd0;
            mtime <= 64'd0;
            presc <= '0;
        end else begin
            // free running, one per clock
            cycle <= cycle + 64'd1;
            // one microsecond every FMAX_MHZ clocks
            if (presc == soc_pkg::PRESC_LAST) begin
                mtime <= mtime + 64'd1;
                presc <= '0;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

    // prescaler wraps before it can reach FMAX_MHZ
    a_presc_range: assert property (
        @(posedge clkConstrained) disable iff (rst)
        presc <= soc_pkg::PRESC_LAST
    ) else $error("prescaler out of range: %0d", presc);

endmodule

/* vlog.f */
soc_pkg.sv
time_counters.sv
word_ram.sv
mmio_regs.sv
mem_ctrl.sv
soc_top.sv
tb_soc_top.sv

/* word_ram.sv */
`timescale 1ns/1ps

module word_ram (
    input  logic                      clkConstrained,
    input  logic [soc_pkg::RAM_AW-1:0] ram_addr,
    input  logic                      ram_we,
    input  logic [31:0]               ram_wdata,
    input  logic [31:0]               ram_wmask,
    output logic [31:0]               ram_rdata
);

    logic [31:0] mem [soc_pkg::RAM_WORDS];
    logic [31:0] cur_word;
    logic [31:0] new_word;

    assign cur_word = mem[ram_addr];

    // only bits with a set mask bit take the new data
    assign new_word = (cur_word & ~ram_wmask) | (ram_wdata & ram_wmask);

    always_ff @(posedge clkConstrained) begin
        if (ram_we) begin
            mem[ram_addr] <= new_word;
        end
    end

    // registered read, returns the word before a same-cycle write
    always_ff @(posedge clkConstrained) begin
        ram_rdata <= cur_word;
    end

endmodule
